// File: hw/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Address and data sizes, in words.
`define DCACHE_ADDR_W 24
`define DCACHE_WORD_W 16

// Address split: tag, set index, word offset.
`define DCACHE_TAG_W 16
`define DCACHE_IDX_W 6
`define DCACHE_SETS 64
`define DCACHE_OFF_W 2

// Four words per line, two ways per set.
`define DCACHE_LINE_W 64
`define DCACHE_WAYS 2

`endif

// File: hw/dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

    // One tag array entry.
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0] tag;
        logic                     valid;
        logic                     dirty;
    } dcache_tag_t;

    // Word 0 sits in the low bits.
    typedef logic [`DCACHE_LINE_W/`DCACHE_WORD_W-1:0][`DCACHE_WORD_W-1:0] dcache_line_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        MERGE_WAIT,
        MERGE,
        UNCACHED
    } dcache_state_t;

endpackage

// File: hw/dcache_mem.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_mem #(
    parameter type T          = dcache_pkg::dcache_line_t,
    parameter bit  CLR_ON_RST = 1'b0
) (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic [`DCACHE_IDX_W-1:0] i_addr,
    input  logic                     i_we,
    input  T                         i_data,
    output T                         o_data
);

    T mem [`DCACHE_SETS];

    // Tag arrays wipe all rows on reset, which drops valid and dirty.
    always_ff @(posedge i_clk) begin
        if (i_rst && CLR_ON_RST) begin
            for (int row = 0; row < `DCACHE_SETS; row++) begin
                mem[row] <= '0;
            end
        end else if (i_we) begin
            mem[i_addr] <= i_data;
        end
    end

    // Registered read, returns the old row on a same-cycle write.
    always_ff @(posedge i_clk) begin
        o_data <= mem[i_addr];
    end

endmodule

// File: hw/dcache_burst.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_burst (
    input  logic                        i_clk,
    input  logic                        i_rst,

    // Command from the controller.
    input  logic                        i_start,
    input  logic                        i_we,
    input  logic                        i_burst,
    input  logic [`DCACHE_ADDR_W-1:0]   i_line_addr,
    input  logic [`DCACHE_WORD_W/8-1:0] i_sel,
    input  dcache_pkg::dcache_line_t    i_line,
    input  logic [`DCACHE_WORD_W-1:0]   i_word,
    output logic                        o_done,
    output dcache_pkg::dcache_line_t    o_line,
    output logic [`DCACHE_WORD_W-1:0]   o_word,

    // Wishbone master.
    output logic                        o_wb_cyc,
    output logic                        o_wb_stb,
    output logic                        o_wb_we,
    output logic [`DCACHE_ADDR_W-1:0]   o_wb_adr,
    output logic [`DCACHE_WORD_W/8-1:0] o_wb_sel,
    output logic [`DCACHE_WORD_W-1:0]   o_wb_dat,
    output logic                        o_wb_4_burst,
    input  logic [`DCACHE_WORD_W-1:0]   i_wb_dat,
    input  logic                        i_wb_ack
);

    import dcache_pkg::*;

    logic                        we_q;
    logic                        burst_q;
    logic [`DCACHE_OFF_W-1:0]    cnt;
    logic [`DCACHE_ADDR_W-1:0]   adr_q;
    logic [`DCACHE_WORD_W/8-1:0] sel_q;
    dcache_line_t                line_q;
    logic [`DCACHE_WORD_W-1:0]   word_q;
    logic                        beat;
    logic                        last;

    assign beat = o_wb_cyc & o_wb_stb & i_wb_ack;
    assign last = burst_q ? (&cnt) : 1'b1;

    // ------------------------------------------------------------
    // Cycle control and beat counter
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            o_done   <= 1'b0;
            we_q     <= 1'b0;
            burst_q  <= 1'b0;
            cnt      <= '0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                o_wb_cyc <= 1'b1;
                o_wb_stb <= 1'b1;
                we_q     <= i_we;
                burst_q  <= i_burst;
                cnt      <= '0;
            end else if (beat) begin
                if (last) begin
                    o_wb_cyc <= 1'b0;
                    o_wb_stb <= 1'b0;
                    o_done   <= 1'b1;  // Engine is idle again here.
                    cnt      <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Payload: outgoing line and word, overwritten by read beats
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_start) begin
            adr_q  <= i_line_addr;
            sel_q  <= i_sel;
            line_q <= i_line;
            word_q <= i_word;
        end else if (beat && !we_q) begin
            line_q[cnt] <= i_wb_dat;
            word_q      <= i_wb_dat;
        end
    end

    // Bursts start at offset 0 and walk the line.
    assign o_wb_adr = burst_q ? {adr_q[`DCACHE_ADDR_W-1:`DCACHE_OFF_W], cnt} : adr_q;
    assign o_wb_sel = burst_q ? '1 : sel_q;
    assign o_wb_dat = burst_q ? line_q[cnt] : word_q;
    assign o_wb_we  = we_q;
    assign o_wb_4_burst = burst_q;

    assign o_line = line_q;
    assign o_word = word_q;

endmodule

// File: hw/dcache.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache (
    input  logic                        i_clk,
    input  logic                        i_rst,

    // CPU port.
    input  logic                        i_mem_req,
    input  logic                        i_mem_we,
    input  logic [`DCACHE_ADDR_W-1:0]   i_mem_addr,
    input  logic [`DCACHE_WORD_W-1:0]   i_mem_data,
    input  logic [`DCACHE_WORD_W/8-1:0] i_mem_sel,
    input  logic                        i_mem_cache_enable,
    output logic                        o_mem_ack,
    output logic [`DCACHE_WORD_W-1:0]   o_mem_data,

    // Tag and data arrays.
    output logic [`DCACHE_IDX_W-1:0]    o_idx,
    output logic [`DCACHE_WAYS-1:0]     o_tag_we,
    output logic [`DCACHE_WAYS-1:0]     o_data_we,
    input  dcache_pkg::dcache_tag_t  [`DCACHE_WAYS-1:0] i_tag_rd,
    input  dcache_pkg::dcache_line_t [`DCACHE_WAYS-1:0] i_line_rd,
    output dcache_pkg::dcache_tag_t     o_tag_wr,
    output dcache_pkg::dcache_line_t    o_line_wr,

    // Burst engine.
    output logic                        o_start,
    output logic                        o_bus_we,
    output logic                        o_burst,
    output logic [`DCACHE_ADDR_W-1:0]   o_line_addr,
    output logic [`DCACHE_WORD_W/8-1:0] o_sel,
    output dcache_pkg::dcache_line_t    o_line,
    output logic [`DCACHE_WORD_W-1:0]   o_word,
    input  logic                        i_done,
    input  dcache_pkg::dcache_line_t    i_line,
    input  logic [`DCACHE_WORD_W-1:0]   i_word
);

    import dcache_pkg::*;

    dcache_state_t              state;
    logic                       lookup_ph;
    logic                       way_q;
    logic [`DCACHE_SETS-1:0]    lru;

    logic [`DCACHE_TAG_W-1:0]   addr_tag;
    logic [`DCACHE_OFF_W-1:0]   off;
    logic [`DCACHE_WAYS-1:0]    hit;
    logic                       any_hit;
    logic                       hit_way;
    logic                       victim;
    logic                       vic_dirty;
    logic                       miss;
    logic                       fill_wr;
    logic                       acc_way;
    logic [`DCACHE_WORD_W-1:0]  merge_word;
    dcache_line_t               merged;

    assign addr_tag = i_mem_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign o_idx    = i_mem_addr[`DCACHE_OFF_W +: `DCACHE_IDX_W];
    assign off      = i_mem_addr[`DCACHE_OFF_W-1:0];

    // ------------------------------------------------------------
    // Tag compare and victim choice
    // ------------------------------------------------------------
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit[w] = i_tag_rd[w].valid && (i_tag_rd[w].tag == addr_tag);
        end
    end

    assign any_hit   = |hit;
    assign hit_way   = hit[1];
    assign victim    = lru[o_idx];  // LRU bit names the way to evict.
    assign vic_dirty = i_tag_rd[victim].valid & i_tag_rd[victim].dirty;
    assign miss      = (state == LOOKUP) && lookup_ph && !any_hit;

    // ------------------------------------------------------------
    // State machine and LRU
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state     <= IDLE;
            lookup_ph <= 1'b0;
            way_q     <= 1'b0;
            lru       <= '0;
        end else begin
            lookup_ph <= (state == LOOKUP);  // Array data is valid from the second cycle.
            if (o_mem_ack && state != UNCACHED) begin
                lru[o_idx] <= ~acc_way;
            end
            case (state)
                IDLE: begin
                    if (i_mem_req) begin
                        state <= i_mem_cache_enable ? LOOKUP : UNCACHED;
                    end
                end
                LOOKUP: begin
                    if (lookup_ph) begin
                        way_q <= any_hit ? hit_way : victim;
                        if (any_hit) begin
                            state <= i_mem_we ? MERGE : IDLE;
                        end else begin
                            state <= vic_dirty ? WRITEBACK : REFILL;
                        end
                    end
                end
                WRITEBACK:  if (i_done) state <= REFILL;
                REFILL:     if (i_done) state <= i_mem_we ? MERGE_WAIT : IDLE;
                MERGE_WAIT: state <= MERGE;  // Refilled row reads back next cycle.
                MERGE:      state <= IDLE;
                UNCACHED:   if (i_done) state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    assign acc_way = (state == LOOKUP) ? hit_way : way_q;

    // ------------------------------------------------------------
    // CPU response
    // ------------------------------------------------------------
    assign o_mem_ack = ((state == LOOKUP) && lookup_ph && any_hit && !i_mem_we) |
                       ((state == REFILL) && i_done && !i_mem_we) |
                       (state == MERGE) |
                       ((state == UNCACHED) && i_done);

    always_comb begin
        case (state)
            UNCACHED: o_mem_data = i_word;
            REFILL:   o_mem_data = i_line[off];  // Straight from the collected line.
            default:  o_mem_data = i_line_rd[hit_way][off];
        endcase
    end

    // ------------------------------------------------------------
    // Byte merge and array writes
    // ------------------------------------------------------------
    always_comb begin
        merged     = i_line_rd[way_q];
        merge_word = merged[off];
        if (i_mem_sel[0]) merge_word[7:0]  = i_mem_data[7:0];
        if (i_mem_sel[1]) merge_word[15:8] = i_mem_data[15:8];
        merged[off] = merge_word;
    end

    assign fill_wr = (state == REFILL) && i_done;

    always_comb begin
        o_tag_wr.tag   = addr_tag;
        o_tag_wr.valid = 1'b1;
        o_tag_wr.dirty = (state == MERGE);
    end

    assign o_line_wr = (state == MERGE) ? merged : i_line;

    // A hit on an already dirty line leaves the tag alone.
    assign o_data_we = (fill_wr || state == MERGE) ? (`DCACHE_WAYS'(1) << way_q) : '0;
    assign o_tag_we  = (fill_wr || (state == MERGE && !i_tag_rd[way_q].dirty)) ?
                       (`DCACHE_WAYS'(1) << way_q) : '0;

    // ------------------------------------------------------------
    // Burst engine commands
    // ------------------------------------------------------------
    assign o_start = ((state == IDLE) && i_mem_req && !i_mem_cache_enable) |
                     miss |
                     ((state == WRITEBACK) && i_done);

    assign o_burst  = (state != IDLE);
    assign o_bus_we = (state == IDLE) ? i_mem_we : ((state == LOOKUP) && vic_dirty);

    always_comb begin
        if (state == IDLE) begin
            o_line_addr = i_mem_addr;
        end else if (state == LOOKUP && vic_dirty) begin
            o_line_addr = {i_tag_rd[victim].tag, o_idx, `DCACHE_OFF_W'(0)};  // Victim line.
        end else begin
            o_line_addr = {i_mem_addr[`DCACHE_ADDR_W-1:`DCACHE_OFF_W], `DCACHE_OFF_W'(0)};
        end
    end

    assign o_sel  = i_mem_sel;
    assign o_line = i_line_rd[victim];
    assign o_word = i_mem_data;

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                        i_clk,
    input  logic                        i_rst,

    input  logic                        i_mem_req,
    input  logic                        i_mem_we,
    input  logic [`DCACHE_ADDR_W-1:0]   i_mem_addr,
    input  logic [`DCACHE_WORD_W-1:0]   i_mem_data,
    input  logic [`DCACHE_WORD_W/8-1:0] i_mem_sel,
    input  logic                        i_mem_cache_enable,
    output logic                        o_mem_ack,
    output logic [`DCACHE_WORD_W-1:0]   o_mem_data,

    output logic                        o_wb_cyc,
    output logic                        o_wb_stb,
    output logic                        o_wb_we,
    output logic [`DCACHE_ADDR_W-1:0]   o_wb_adr,
    output logic [`DCACHE_WORD_W/8-1:0] o_wb_sel,
    output logic [`DCACHE_WORD_W-1:0]   o_wb_dat,
    output logic                        o_wb_4_burst,
    input  logic [`DCACHE_WORD_W-1:0]   i_wb_dat,
    input  logic                        i_wb_ack
);

    import dcache_pkg::*;

    logic [`DCACHE_IDX_W-1:0]         idx;
    logic [`DCACHE_WAYS-1:0]          tag_we;
    logic [`DCACHE_WAYS-1:0]          data_we;
    dcache_tag_t  [`DCACHE_WAYS-1:0]  tag_rd;
    dcache_line_t [`DCACHE_WAYS-1:0]  line_rd;
    dcache_tag_t                      tag_wr;
    dcache_line_t                     line_wr;

    logic                             start;
    logic                             bus_we;
    logic                             burst;
    logic [`DCACHE_ADDR_W-1:0]        line_addr;
    logic [`DCACHE_WORD_W/8-1:0]      sel;
    dcache_line_t                     out_line;
    logic [`DCACHE_WORD_W-1:0]        out_word;
    logic                             done;
    dcache_line_t                     in_line;
    logic [`DCACHE_WORD_W-1:0]        in_word;

    dcache i_ctrl (
        .i_clk, .i_rst,
        .i_mem_req, .i_mem_we, .i_mem_addr, .i_mem_data, .i_mem_sel, .i_mem_cache_enable,
        .o_mem_ack, .o_mem_data,
        .o_idx(idx), .o_tag_we(tag_we), .o_data_we(data_we),
        .i_tag_rd(tag_rd), .i_line_rd(line_rd), .o_tag_wr(tag_wr), .o_line_wr(line_wr),
        .o_start(start), .o_bus_we(bus_we), .o_burst(burst), .o_line_addr(line_addr),
        .o_sel(sel), .o_line(out_line), .o_word(out_word),
        .i_done(done), .i_line(in_line), .i_word(in_word)
    );

    // ------------------------------------------------------------
    // Per-way arrays
    // ------------------------------------------------------------
    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        dcache_mem #(.T(dcache_tag_t), .CLR_ON_RST(1'b1)) i_tag (
            .i_clk, .i_rst, .i_addr(idx), .i_we(tag_we[w]),
            .i_data(tag_wr), .o_data(tag_rd[w])
        );
        dcache_mem #(.T(dcache_line_t)) i_data (
            .i_clk, .i_rst, .i_addr(idx), .i_we(data_we[w]),
            .i_data(line_wr), .o_data(line_rd[w])
        );
    end

    dcache_burst i_burst (
        .i_clk, .i_rst,
        .i_start(start), .i_we(bus_we), .i_burst(burst), .i_line_addr(line_addr),
        .i_sel(sel), .i_line(out_line), .i_word(out_word),
        .o_done(done), .o_line(in_line), .o_word(in_word),
        .o_wb_cyc, .o_wb_stb, .o_wb_we, .o_wb_adr, .o_wb_sel, .o_wb_dat, .o_wb_4_burst,
        .i_wb_dat, .i_wb_ack
    );

endmodule

// File: verification/dcache_asserts.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_asserts (
    input logic                        i_clk,
    input logic                        i_rst,
    input logic                        i_mem_req,
    input logic                        o_mem_ack,
    input logic                        o_wb_cyc,
    input logic                        o_wb_stb,
    input logic                        o_wb_we,
    input logic [`DCACHE_ADDR_W-1:0]   o_wb_adr,
    input logic [`DCACHE_WORD_W-1:0]   o_wb_dat,
    input logic                        i_wb_ack,
    input dcache_pkg::dcache_state_t   i_state
);

    import dcache_pkg::*;

    a_ack_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        o_mem_ack |=> !o_mem_ack)
        else $error("CPU ack stayed high for two cycles");

    a_stb_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
        o_wb_stb |-> o_wb_cyc)
        else $error("Wishbone stb high without cyc");

    // Address, direction and data hold while a beat waits for ack.
    a_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_wb_stb && !i_wb_ack) |=> ($stable(o_wb_adr) && $stable(o_wb_we) && $stable(o_wb_dat)))
        else $error("Wishbone request changed while waiting for ack");

    a_no_spurious: assert property (@(posedge i_clk) disable iff (i_rst)
        (!o_wb_cyc && i_state == IDLE && !i_mem_req) |=> !o_wb_cyc)
        else $error("Wishbone cycle started from IDLE without a CPU request");

endmodule

bind dcache_top dcache_asserts i_asserts (
    .i_clk(i_clk), .i_rst(i_rst), .i_mem_req(i_mem_req), .o_mem_ack(o_mem_ack),
    .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we), .o_wb_adr(o_wb_adr),
    .o_wb_dat(o_wb_dat), .i_wb_ack(i_wb_ack), .i_state(i_ctrl.state)
);

// File: verification/dcache_checker.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_checker (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  int                          i_test_id,
    input  logic                        i_mem_req,
    input  logic                        i_mem_we,
    input  logic [`DCACHE_ADDR_W-1:0]   i_mem_addr,
    input  logic [`DCACHE_WORD_W-1:0]   i_mem_data,
    input  logic [`DCACHE_WORD_W/8-1:0] i_mem_sel,
    input  logic                        i_mem_ack,
    input  logic [`DCACHE_WORD_W-1:0]   i_mem_rdata,
    input  logic                        i_wb_cyc,
    input  logic                        i_wb_stb,
    input  logic                        i_wb_we,
    input  logic                        i_wb_4_burst,
    input  logic [`DCACHE_ADDR_W-1:0]   i_wb_adr,
    input  logic [`DCACHE_WORD_W-1:0]   i_wb_dat,
    input  logic                        i_wb_ack,
    output int                          o_errors,
    output int                          o_checks
);

    logic [`DCACHE_WORD_W-1:0] ref_mem [logic [`DCACHE_ADDR_W-1:0]];
    int errors = 0;
    int checks = 0;

    assign o_errors = errors;
    assign o_checks = checks;

    function automatic string test_label(input int id);
        case (id)
            1:       return "read_after_reset";
            2:       return "write_hit";
            3:       return "eviction";
            4:       return "uncached";
            5:       return "random_mix";
            default: return "setup";
        endcase
    endfunction

    // Power-up contents, the same pattern the memory model starts from.
    function automatic logic [15:0] ref_read(input logic [23:0] a);
        if (ref_mem.exists(a)) return ref_mem[a];
        return {a[7:0], a[15:8]} ^ {8'h00, a[23:16]} ^ 16'h3c5a;
    endfunction

    always @(posedge i_clk) begin
        logic [15:0] w;
        if (!i_rst) begin
            if (i_mem_req && i_mem_ack) begin
                w = ref_read(i_mem_addr);
                if (i_mem_we) begin
                    if (i_mem_sel[0]) w[7:0]  = i_mem_data[7:0];
                    if (i_mem_sel[1]) w[15:8] = i_mem_data[15:8];
                    ref_mem[i_mem_addr] = w;
                end else begin
                    checks++;
                    if (i_mem_rdata !== w) begin
                        errors++;
                        $display("CHECK FAILED %s read @%h expected %h actual %h",
                                 test_label(i_test_id), i_mem_addr, w, i_mem_rdata);
                    end
                end
            end
            // Writeback beats must carry the latest CPU data.
            if (i_wb_cyc && i_wb_stb && i_wb_ack && i_wb_we && i_wb_4_burst) begin
                w = ref_read(i_wb_adr);
                checks++;
                if (i_wb_dat !== w) begin
                    errors++;
                    $display("CHECK FAILED %s writeback @%h expected %h actual %h",
                             test_label(i_test_id), i_wb_adr, w, i_wb_dat);
                end
            end
        end
    end

endmodule

// File: verification/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tb;

    localparam int ACK_TIMEOUT = 200;
    localparam int HIT_LATENCY = 3;  // Drive edge, IDLE sample, LOOKUP read, ack.

    logic        i_clk = 1'b0;
    logic        i_rst = 1'b1;
    logic        i_mem_req = 1'b0;
    logic        i_mem_we = 1'b0;
    logic [23:0] i_mem_addr = '0;
    logic [15:0] i_mem_data = '0;
    logic [1:0]  i_mem_sel = '0;
    logic        i_mem_cache_enable = 1'b0;
    logic        o_mem_ack;
    logic [15:0] o_mem_data;
    logic        o_wb_cyc, o_wb_stb, o_wb_we, o_wb_4_burst;
    logic [23:0] o_wb_adr;
    logic [1:0]  o_wb_sel;
    logic [15:0] o_wb_dat;
    logic [15:0] i_wb_dat = '0;
    logic        i_wb_ack = 1'b0;

    int          test_id = 0;
    int          tb_errors = 0;
    int          tb_checks = 0;
    int          chk_errors, chk_checks;
    int          beats, lat;
    logic        saw_burst;
    logic [1:0]  beat_sel;
    logic        reported = 1'b0;
    logic [31:0] rnd = 32'd78593;
    logic [31:0] bus_rnd;
    logic [1:0]  stall = '0;
    logic [15:0] wb_mem [logic [23:0]];
    logic [15:0] tags [3] = '{16'h0012, 16'h0345, 16'h0a71};
    logic [5:0]  sets [2] = '{6'd5, 6'd33};

    always #5 i_clk = ~i_clk;

    dcache_top i_dut (.*);

    dcache_checker i_chk (
        .i_clk, .i_rst, .i_test_id(test_id),
        .i_mem_req, .i_mem_we, .i_mem_addr, .i_mem_data, .i_mem_sel,
        .i_mem_ack(o_mem_ack), .i_mem_rdata(o_mem_data),
        .i_wb_cyc(o_wb_cyc), .i_wb_stb(o_wb_stb), .i_wb_we(o_wb_we),
        .i_wb_4_burst(o_wb_4_burst), .i_wb_adr(o_wb_adr), .i_wb_dat(o_wb_dat),
        .i_wb_ack, .o_errors(chk_errors), .o_checks(chk_checks)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [23:0] make_addr(input logic [15:0] t, input logic [5:0] s,
                                              input logic [1:0] o);
        return {t, s, o};
    endfunction

    function automatic logic [15:0] mem_read(input logic [23:0] a);
        if (wb_mem.exists(a)) return wb_mem[a];
        return {a[7:0], a[15:8]} ^ {8'h00, a[23:16]} ^ 16'h3c5a;
    endfunction

    // ------------------------------------------------------------
    // Wishbone memory with 0 to 3 stall cycles per beat
    // ------------------------------------------------------------
    initial bus_rnd = xorshift(32'd78593);

    always @(posedge i_clk) begin
        logic [15:0] w;
        if (i_rst) begin
            i_wb_ack <= 1'b0;
        end else if (o_wb_cyc && o_wb_stb) begin
            if (i_wb_ack) begin
                i_wb_ack <= 1'b0;
                if (o_wb_we) begin
                    w = mem_read(o_wb_adr);
                    if (o_wb_sel[0]) w[7:0]  = o_wb_dat[7:0];
                    if (o_wb_sel[1]) w[15:8] = o_wb_dat[15:8];
                    wb_mem[o_wb_adr] = w;
                end
                bus_rnd = xorshift(bus_rnd);
                stall <= bus_rnd[1:0];
            end else if (stall == 0) begin
                i_wb_ack <= 1'b1;
                i_wb_dat <= mem_read(o_wb_adr);
            end else begin
                stall <= stall - 1'b1;
            end
        end
    end

    task automatic report_and_finish();
        reported = 1'b1;
        $display("errors: %0d  checks: %0d", tb_errors + chk_errors, tb_checks + chk_checks);
        if (tb_errors == 0 && chk_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input int exp, input int act);
        tb_checks++;
        if (exp != act) begin
            tb_errors++;
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // One CPU request, held until ack; also counts the Wishbone beats.
    task automatic cpu_access(input logic we, input logic [23:0] addr, input logic [15:0] data,
                              input logic [1:0] sel, input logic ce);
        int waited;
        waited = 0;
        beats = 0;
        saw_burst = 1'b0;
        @(posedge i_clk);
        i_mem_req          <= 1'b1;
        i_mem_we           <= we;
        i_mem_addr         <= addr;
        i_mem_data         <= data;
        i_mem_sel          <= sel;
        i_mem_cache_enable <= ce;
        do begin
            @(posedge i_clk);
            waited++;
            if (o_wb_cyc && o_wb_stb && i_wb_ack) begin
                beats++;
                beat_sel = o_wb_sel;
                saw_burst |= o_wb_4_burst;
            end
        end while (!o_mem_ack && waited < ACK_TIMEOUT);
        i_mem_req <= 1'b0;
        lat = waited;
        if (!o_mem_ack) begin
            tb_errors++;
            $display("Timeout: no CPU ack for the access to address %h", addr);
            report_and_finish();
        end
    endtask

    initial begin
        logic [23:0] a;
        repeat (16) @(posedge i_clk);
        i_rst <= 1'b0;

        test_id <= 1;
        for (int o = 0; o < 4; o++) cpu_access(0, make_addr(tags[0], sets[0], 2'(o)), 0, 2'b11, 1);
        cpu_access(0, make_addr(tags[0], sets[0], 2'd2), 0, 2'b11, 1);
        check_value("read_hit_latency", HIT_LATENCY, lat);

        test_id <= 2;
        a = make_addr(tags[0], sets[0], 2'd1);
        cpu_access(1, a, 16'h12ab, 2'b01, 1);
        cpu_access(0, a, 0, 2'b11, 1);
        cpu_access(1, a, 16'hcd34, 2'b10, 1);
        cpu_access(0, a, 0, 2'b11, 1);
        cpu_access(1, a + 24'd1, 16'hbeef, 2'b11, 1);
        cpu_access(0, a + 24'd1, 0, 2'b11, 1);

        test_id <= 3;
        for (int r = 0; r < 2; r++) begin
            for (int t = 0; t < 3; t++) begin
                cpu_access(1, make_addr(tags[t], sets[1], 2'(t)), 16'(16'h1100 * (t + 1) + r),
                           2'b11, 1);
            end
        end
        for (int t = 0; t < 3; t++) cpu_access(0, make_addr(tags[t], sets[1], 2'(t)), 0, 2'b11, 1);

        test_id <= 4;
        a = make_addr(16'h7f00, sets[0], 2'd3);
        cpu_access(1, a, 16'h5a00, 2'b10, 0);
        check_value("uncached_write_beats", 1, beats);
        check_value("uncached_write_burst", 0, saw_burst);
        check_value("uncached_write_sel", 2, beat_sel);
        cpu_access(0, a, 0, 2'b01, 0);
        check_value("uncached_read_beats", 1, beats);
        check_value("uncached_read_burst", 0, saw_burst);
        check_value("uncached_read_sel", 1, beat_sel);
        check_value("uncached_read_data", mem_read(a), o_mem_data);

        // Uncached traffic uses its own tag so it never aliases a cached line.
        test_id <= 5;
        for (int n = 0; n < 400; n++) begin
            rnd = xorshift(rnd);
            if (rnd[3:2] == 2'b00) begin
                a = make_addr(16'h7f00, sets[rnd[4]], rnd[6:5]);
            end else begin
                a = make_addr(tags[rnd[8:7] % 3], sets[rnd[4]], rnd[6:5]);
            end
            cpu_access(rnd[0], a, rnd[31:16], (rnd[10:9] == 2'b00) ? 2'b11 : rnd[10:9],
                       rnd[3:2] != 2'b00);
        end

        repeat (4) @(posedge i_clk);
        report_and_finish();
    end

    // A run stopped from elsewhere still ends with a verdict.
    final begin
        if (!reported) $display(">>> FAIL");
    end

endmodule

// File: project.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_mem.sv
hw/dcache_burst.sv
hw/dcache.sv
hw/dcache_top.sv
verification/dcache_asserts.sv
verification/dcache_checker.sv
verification/dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it and grep the log for the verdict.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module dcache_tb -Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
